// File: vlog.f
design/fdsu_format_pkg.sv
design/fdsu_ctrl_pkg.sv
design/fdsu_iter_if.sv
design/fdsu_main_fsm.sv
design/fdsu_srt_counter.sv
design/fdsu_scalar_ctrl.sv
testbench/fdsu_ctrl_checker.sv
testbench/tb_fdsu_scalar_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator; the log must hold the pass message
rm -f build.log sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_fdsu_scalar_ctrl \
  -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: testbench/tb_fdsu_scalar_ctrl.sv
// Testbench top for the divide/sqrt control block: clock, reset, issue sequences and timeout
`timescale 1ns/1ns

module tb_fdsu_scalar_ctrl
  import fdsu_format_pkg::*;
();

  // Longest op plus grant delay and gap, times the op count
  localparam int TIMEOUT_CYCLES = 48 * 48 + 16 + 100;

  logic        fdsu_clk = 1'b0;
  logic        cpurst_b;
  logic        ex1_sel, ex1_div, ex1_op0_denorm, ex1_op1_denorm, ex1_srt_skip;
  fdsu_fmt_e   ex1_fmt;
  logic        ex2_range_skip, srt_remainder_zero, wb_grant, warm_up, async_flush;
  logic        ex1_stall, wb_req, state_idle, busy, srt_sm_on;
  logic        ex1_pipedown, ex2_pipedown, ex3_pipedown, ex4_pipedown;
  logic        ex2_srt_first_round, op1_sel, save_op0, save_ff1_op1;
  int          cycles = 0;
  logic [31:0] rnd;

  always #5 fdsu_clk = ~fdsu_clk;

  fdsu_scalar_ctrl u_dut (.*);
  fdsu_ctrl_checker u_chk (.*);

  always @(posedge fdsu_clk)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, an operation never finished", cycles);
      $display("Checks: %0d, errors: %0d", u_chk.chk_cnt, u_chk.err_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  //==================================================
  // Issue and writeback
  //==================================================
  // Fields stay put until ex1 lets the op go
  task automatic issue(input fdsu_fmt_e fmt, input logic div, input logic dn0,
                       input logic dn1, input logic [2:0] skips);
    @(negedge fdsu_clk);
    ex1_sel = 1'b1;
    ex1_fmt = fmt;
    ex1_div = div;
    ex1_op0_denorm = dn0;
    ex1_op1_denorm = dn1;
    ex1_srt_skip = skips[0];
    ex2_range_skip = skips[1];
    srt_remainder_zero = skips[2];
    @(posedge fdsu_clk);
    while (ex1_stall)
      @(posedge fdsu_clk);
    @(negedge fdsu_clk);
    ex1_sel = 1'b0;
  endtask

  task automatic complete(input int grant_delay);
    while (!wb_req)
      @(negedge fdsu_clk);
    repeat (grant_delay)
      @(negedge fdsu_clk);
    wb_grant = 1'b1;
    @(negedge fdsu_clk);
    wb_grant = 1'b0;
    ex2_range_skip = 1'b0;
    srt_remainder_zero = 1'b0;
    repeat ($urandom_range(4, 0))
      @(negedge fdsu_clk);
  endtask

  // Cut a double divide short a few cycles into iteration
  task automatic flush_op(input logic by_warm_up);
    issue(fmt_double, 1'b1, 1'b0, 1'b0, 3'b000);
    repeat (3)
      @(negedge fdsu_clk);
    warm_up = by_warm_up;
    async_flush = !by_warm_up;
    @(negedge fdsu_clk);
    warm_up = 1'b0;
    async_flush = 1'b0;
    repeat (2)
      @(negedge fdsu_clk);
  endtask

  //==================================================
  // Test sequence
  //==================================================
  initial
  begin
    void'($urandom(32'h34c701ce));
    cpurst_b = 1'b0;
    ex1_sel = 1'b0;
    ex1_fmt = fmt_double;
    ex1_div = 1'b0;
    ex1_op0_denorm = 1'b0;
    ex1_op1_denorm = 1'b0;
    ex1_srt_skip = 1'b0;
    ex2_range_skip = 1'b0;
    srt_remainder_zero = 1'b0;
    wb_grant = 1'b0;
    warm_up = 1'b0;
    async_flush = 1'b0;
    repeat (16)
      @(posedge fdsu_clk);
    @(negedge fdsu_clk);
    cpurst_b = 1'b1;
    repeat (3)
      @(negedge fdsu_clk);
    for (int f = 0; f < 4; f++)
      for (int dv = 0; dv < 2; dv++)
      begin
        issue(fdsu_fmt_e'(f[1:0]), dv[0], 1'b0, 1'b0, 3'b000);
        complete(0);
      end
    // Random formats and denormal flags
    repeat (16)
    begin
      rnd = $urandom;
      issue(fdsu_fmt_e'(rnd[1:0]), rnd[2], rnd[3], rnd[4], 3'b000);
      complete(0);
    end
    // Each early-termination source on its own
    for (int s = 0; s < 3; s++)
      repeat (4)
      begin
        rnd = $urandom;
        issue(fdsu_fmt_e'(rnd[1:0]), rnd[2], rnd[3], rnd[4], 3'(1 << s));
        complete(0);
      end
    // Writeback back-pressure
    repeat (8)
    begin
      rnd = $urandom;
      issue(fdsu_fmt_e'(rnd[1:0]), rnd[2], rnd[3], rnd[4], 3'b000);
      complete(int'($urandom_range(8, 0)));
    end
    flush_op(1'b0);
    issue(fmt_single, 1'b1, 1'b0, 1'b0, 3'b000);
    complete(0);
    flush_op(1'b1);
    issue(fmt_half, 1'b0, 1'b0, 1'b0, 3'b000);
    complete(0);
    repeat (4)
      @(negedge fdsu_clk);
    $display("Checks: %0d, errors: %0d", u_chk.chk_cnt, u_chk.err_cnt);
    if (u_chk.err_cnt == 0 && u_chk.chk_cnt > 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: testbench/fdsu_ctrl_checker.sv
// Checker for the divide/sqrt control block, instantiated beside the DUT by the testbench top
`timescale 1ns/1ns

module fdsu_ctrl_checker
  import fdsu_format_pkg::*;
(
  input logic      fdsu_clk, cpurst_b,
  input logic      ex1_sel, ex1_div, ex1_op0_denorm, ex1_op1_denorm,
  input fdsu_fmt_e ex1_fmt,
  input logic      ex1_srt_skip, ex2_range_skip, srt_remainder_zero,
  input logic      ex1_stall, wb_req, wb_grant, warm_up, async_flush,
  input logic      state_idle, busy, srt_sm_on,
  input logic      op1_sel, save_op0, save_ff1_op1,
  input logic      ex1_pipedown, ex2_pipedown, ex3_pipedown, ex4_pipedown,
  input logic      ex2_srt_first_round
);

  int   err_cnt = 0;
  int   chk_cnt = 0;
  int   lat, exp_lat, stalls, exp_stalls, strobe_seq;
  int   pd_cnt, sm_cnt, exp_iter, op1_cnt, exp_op1, save_cnt, exp_save;
  logic in_op, wait_grant, idle_due, seen_issue, prev_pd;

  //==================================================
  // Reference model
  //==================================================
  // Extra ex1 cycles for denormal normalization
  function automatic int ref_stalls(logic div, logic dn0, logic dn1);
    return (dn0 ? 1 : 0) + ((div && dn1) ? 2 : 0);
  endfunction

  // Issue to wb_req: iterate length, then rnd, pack and the step into wfwb
  function automatic int ref_latency(fdsu_fmt_e fmt, logic div, logic dn0, logic dn1,
                                     logic skip);
    int n;
    case (fmt)
      fmt_double: n = int'(SRT_CNT_DOUBLE);
      fmt_single: n = int'(SRT_CNT_SINGLE);
      fmt_half:   n = int'(SRT_CNT_HALF);
      default:    n = int'(SRT_CNT_BHALF);
    endcase
    return (skip ? 1 : n + 1) + 3 + ref_stalls(div, dn0, dn1);
  endfunction

  task automatic check(input logic ok, input string msg);
    chk_cnt++;
    if (!ok)
    begin
      err_cnt++;
      $display("error at %0t ns: %s", $time, msg);
    end
  endtask

  //==================================================
  // Comparison
  //==================================================
  always @(posedge fdsu_clk)
  begin
    if (!cpurst_b)
    begin
      in_op = 1'b0;
      wait_grant = 1'b0;
      idle_due = 1'b0;
      seen_issue = 1'b0;
      prev_pd = 1'b0;
    end
    else
    begin
      if (!seen_issue && !ex1_sel)
        check(!wb_req && !ex1_stall && !busy && state_idle && !ex1_pipedown
              && !ex2_pipedown && !ex3_pipedown && !ex4_pipedown
              && !srt_sm_on && !ex2_srt_first_round
              && !op1_sel && !save_op0 && !save_ff1_op1,
              "outputs not at reset values before the first issue");
      if (idle_due)
        check(state_idle && !wb_req, "state_idle not high after grant or flush");
      idle_due = 1'b0;
      if (warm_up)
        check(ex1_pipedown && ex2_pipedown && ex3_pipedown && ex4_pipedown,
              "warm_up did not force every pipedown");
      if (warm_up || async_flush)
      begin
        // In-flight operation is dropped
        in_op = 1'b0;
        wait_grant = 1'b0;
        idle_due = 1'b1;
      end
      else if (in_op)
      begin
        lat++;
        stalls += int'(ex1_stall);
        pd_cnt += int'(ex1_pipedown);
        sm_cnt += int'(srt_sm_on);
        op1_cnt += int'(op1_sel);
        save_cnt += int'(save_op0) + int'(save_ff1_op1);
        check(ex2_srt_first_round == prev_pd,
              "ex2_srt_first_round not exactly one cycle after ex1_pipedown");
        if (lat == 1)
          check(!state_idle, "state_idle still high after issue");
        if (ex2_pipedown)
          strobe_seq = strobe_seq * 10 + 2;
        if (ex3_pipedown)
          strobe_seq = strobe_seq * 10 + 3;
        if (ex4_pipedown)
          strobe_seq = strobe_seq * 10 + 4;
        if (wb_req)
        begin
          check(lat == exp_lat, $sformatf("latency %0d, expected %0d", lat, exp_lat));
          check(stalls == exp_stalls,
                $sformatf("ex1_stall cycles %0d, expected %0d", stalls, exp_stalls));
          check(strobe_seq == 234, $sformatf("pipedown order %0d, expected 234", strobe_seq));
          check(pd_cnt == 1, $sformatf("ex1_pipedown pulses %0d, expected 1", pd_cnt));
          check(sm_cnt == exp_iter,
                $sformatf("srt_sm_on cycles %0d, expected %0d", sm_cnt, exp_iter));
          check(op1_cnt == exp_op1,
                $sformatf("op1_sel cycles %0d, expected %0d", op1_cnt, exp_op1));
          check(save_cnt == exp_save,
                $sformatf("operand save cycles %0d, expected %0d", save_cnt, exp_save));
          in_op = 1'b0;
          wait_grant = 1'b1;
        end
      end
      else if (!wait_grant && state_idle && ex1_sel)
      begin
        seen_issue = 1'b1;
        in_op = 1'b1;
        lat = 0;
        stalls = int'(ex1_stall);
        strobe_seq = 0;
        pd_cnt = int'(ex1_pipedown);
        sm_cnt = 0;
        op1_cnt = 0;
        save_cnt = 0;
        exp_lat = ref_latency(ex1_fmt, ex1_div, ex1_op0_denorm, ex1_op1_denorm,
                              ex1_srt_skip || ex2_range_skip || srt_remainder_zero);
        exp_stalls = ref_stalls(ex1_div, ex1_op0_denorm, ex1_op1_denorm);
        // Whatever is left after the ex1 stalls and rnd, pack, wfwb
        exp_iter = exp_lat - 3 - exp_stalls;
        // op1 gets the wait and normalize states, op0 is parked if it went first
        exp_op1 = (ex1_div && ex1_op1_denorm) ? 2 : 0;
        exp_save = (ex1_div && ex1_op1_denorm) ? 1 + int'(ex1_op0_denorm) : 0;
      end
      else if (wb_req && !wait_grant)
        check(1'b0, "wb_req without an operation in flight");
      if (wait_grant)
      begin
        check(wb_req && busy, "wb_req or busy dropped before the grant");
        if (wb_grant)
        begin
          wait_grant = 1'b0;
          idle_due = 1'b1;
        end
      end
      prev_pd = ex1_pipedown;
    end
  end

endmodule

// File: design/fdsu_scalar_ctrl.sv
// Top level of the scalar divide/sqrt control block, joining the sequencer and iteration counter
`timescale 1ns/1ns

module fdsu_scalar_ctrl
  import fdsu_format_pkg::*;
(
  input  logic       fdsu_clk,
  input  logic       cpurst_b,
  // Issue
  input  logic       ex1_sel,
  input  fdsu_fmt_e  ex1_fmt,
  input  logic       ex1_div,
  input  logic       ex1_op0_denorm,
  input  logic       ex1_op1_denorm,
  input  logic       ex1_srt_skip,
  output logic       ex1_stall,
  // Datapath feedback
  input  logic       ex2_range_skip,
  input  logic       srt_remainder_zero,
  // Writeback
  output logic       wb_req,
  input  logic       wb_grant,
  // Flush
  input  logic       warm_up,
  input  logic       async_flush,
  // Status
  output logic       state_idle,
  output logic       busy,
  output logic       srt_sm_on,
  // Pipeline strobes
  output logic       ex1_pipedown,
  output logic       ex2_pipedown,
  output logic       ex3_pipedown,
  output logic       ex4_pipedown,
  output logic       ex2_srt_first_round,
  // Datapath selects
  output logic       op1_sel,
  output logic       save_op0,
  output logic       save_ff1_op1
);

  fdsu_iter_if iter ();

  fdsu_main_fsm u_fsm (
    .fdsu_clk       (fdsu_clk),
    .cpurst_b       (cpurst_b),
    .ex1_sel        (ex1_sel),
    .ex1_div        (ex1_div),
    .ex1_op0_denorm (ex1_op0_denorm),
    .ex1_op1_denorm (ex1_op1_denorm),
    .wb_grant       (wb_grant),
    .warm_up        (warm_up),
    .async_flush    (async_flush),
    .iter           (iter.fsm),
    .ex1_stall      (ex1_stall),
    .wb_req         (wb_req),
    .state_idle     (state_idle),
    .busy           (busy),
    .srt_sm_on      (srt_sm_on),
    .ex2_pipedown   (ex2_pipedown),
    .ex3_pipedown   (ex3_pipedown),
    .ex4_pipedown   (ex4_pipedown),
    .op1_sel        (op1_sel),
    .save_op0       (save_op0),
    .save_ff1_op1   (save_ff1_op1)
  );

  fdsu_srt_counter u_cnt (
    .fdsu_clk            (fdsu_clk),
    .cpurst_b            (cpurst_b),
    .ex1_fmt             (ex1_fmt),
    .ex1_srt_skip        (ex1_srt_skip),
    .ex2_range_skip      (ex2_range_skip),
    .srt_remainder_zero  (srt_remainder_zero),
    .iter                (iter.cnt),
    .ex2_srt_first_round (ex2_srt_first_round)
  );

  // ex1 strobe also feeds the operand latches outside this block
  assign ex1_pipedown = iter.ex1_pipedown;

endmodule

// File: design/fdsu_srt_counter.sv
// SRT iteration counter with skip capture, last-round detection and first-round flag
`timescale 1ns/1ns

module fdsu_srt_counter
  import fdsu_format_pkg::*;
(
  input  logic          fdsu_clk,
  input  logic          cpurst_b,
  input  fdsu_fmt_e     ex1_fmt,
  input  logic          ex1_srt_skip,
  input  logic          ex2_range_skip,
  input  logic          srt_remainder_zero,
  fdsu_iter_if.cnt      iter,
  output logic          ex2_srt_first_round
);

  logic [SRT_CNT_W-1:0] srt_cnt;
  logic [SRT_CNT_W-1:0] srt_cnt_ini;
  logic                 srt_cnt_zero;
  logic                 ex2_special_skip;

  //==================================================
  // Start value
  //==================================================
  always_comb
  begin
    case (ex1_fmt)
      fmt_double: srt_cnt_ini = SRT_CNT_DOUBLE;
      fmt_single: srt_cnt_ini = SRT_CNT_SINGLE;
      fmt_half:   srt_cnt_ini = SRT_CNT_HALF;
      default:    srt_cnt_ini = SRT_CNT_BHALF;
    endcase
  end

  //==================================================
  // Counter
  //==================================================
  // Stops at zero instead of wrapping on the final round
  always_ff @(posedge fdsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      srt_cnt <= '0;
    else if (iter.flush)
      srt_cnt <= '0;
    else if (iter.iter_start)
      srt_cnt <= srt_cnt_ini;
    else if (iter.itering && !srt_cnt_zero)
      srt_cnt <= srt_cnt - SRT_CNT_W'(1);
  end

  assign srt_cnt_zero = (srt_cnt == '0);

  // Special-case result known at issue, carried into ex2
  always_ff @(posedge fdsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex2_special_skip <= 1'b0;
    else if (iter.ex1_pipedown)
      ex2_special_skip <= ex1_srt_skip;
  end

  assign iter.last_round = iter.itering
                        && (srt_cnt_zero || ex2_special_skip
                            || ex2_range_skip || srt_remainder_zero);

  //==================================================
  // First round flag
  //==================================================
  always_ff @(posedge fdsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex2_srt_first_round <= 1'b0;
    else if (iter.flush)
      ex2_srt_first_round <= 1'b0;
    else
      ex2_srt_first_round <= iter.ex1_pipedown;
  end

  // Count only moves down during iteration
  a_no_wrap: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    (iter.itering && !iter.flush) |=> (srt_cnt <= $past(srt_cnt)));

endmodule

// File: design/fdsu_main_fsm.sv
// Divide/sqrt sequencer: state machine, denormal stall, flush, pipeline strobes and writeback request
`timescale 1ns/1ns

module fdsu_main_fsm
  import fdsu_ctrl_pkg::*;
(
  input  logic          fdsu_clk,
  input  logic          cpurst_b,
  input  logic          ex1_sel,
  input  logic          ex1_div,
  input  logic          ex1_op0_denorm,
  input  logic          ex1_op1_denorm,
  input  logic          wb_grant,
  input  logic          warm_up,
  input  logic          async_flush,
  fdsu_iter_if.fsm      iter,
  output logic          ex1_stall,
  output logic          wb_req,
  output logic          state_idle,
  output logic          busy,
  output logic          srt_sm_on,
  output logic          ex2_pipedown,
  output logic          ex3_pipedown,
  output logic          ex4_pipedown,
  output logic          op1_sel,
  output logic          save_op0,
  output logic          save_ff1_op1
);

  fdsu_state_e cur_state;
  fdsu_state_e next_state;
  logic        dn_op0;
  logic        dn_op1;
  logic        sm_start;
  logic        dn_stall;
  logic        flush;
  logic        st_is_idle;
  logic        st_is_wfi2;
  logic        st_is_iter;
  logic        st_is_rnd;
  logic        st_is_pack;
  logic        st_is_wfwb;
  logic        st_is_id0;
  logic        st_is_id1;

  //==================================================
  // Issue qualification
  //==================================================
  // op1 only matters for a divide
  assign dn_op0   = ex1_sel && ex1_op0_denorm;
  assign dn_op1   = ex1_sel && ex1_div && ex1_op1_denorm;
  assign sm_start = ex1_sel && st_is_idle;
  assign flush    = warm_up || async_flush;

  //==================================================
  // State machine
  //==================================================
  always_ff @(posedge fdsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= st_idle;
    else if (flush)
      cur_state <= st_idle;
    else
      cur_state <= next_state;
  end

  always_comb
  begin
    case (cur_state)
      st_idle:
      begin
        if (!ex1_sel)
          next_state = st_idle;
        else if (dn_op0)
          next_state = st_id0;
        else if (dn_op1)
          next_state = st_wfi2;
        else
          next_state = st_iter;
      end
      st_id0:  next_state = dn_op1 ? st_wfi2 : st_iter;
      st_wfi2: next_state = st_id1;
      st_id1:  next_state = st_iter;
      st_iter: next_state = iter.last_round ? st_rnd : st_iter;
      st_rnd:  next_state = st_pack;
      st_pack: next_state = st_wfwb;
      st_wfwb: next_state = wb_grant ? st_idle : st_wfwb;
      default: next_state = st_idle;
    endcase
  end

  // State decodes
  assign st_is_idle = (cur_state == st_idle);
  assign st_is_wfi2 = (cur_state == st_wfi2);
  assign st_is_iter = (cur_state == st_iter);
  assign st_is_rnd  = (cur_state == st_rnd);
  assign st_is_pack = (cur_state == st_pack);
  assign st_is_wfwb = (cur_state == st_wfwb);
  assign st_is_id0  = (cur_state == st_id0);
  assign st_is_id1  = (cur_state == st_id1);

  //==================================================
  // Denormal stall and iteration start
  //==================================================
  assign dn_stall  = st_is_wfi2
                  || (st_is_id0 && dn_op1)
                  || (sm_start && (dn_op0 || dn_op1));
  assign ex1_stall = ex1_sel && dn_stall;

  // Last ex1 cycle of the operation, whichever path it took
  assign iter.iter_start   = (sm_start && !dn_op0 && !dn_op1)
                          || (st_is_id0 && !dn_op1)
                          || st_is_id1;
  assign iter.itering      = st_is_iter;
  assign iter.flush        = flush;

  //==================================================
  // Pipeline strobes
  //==================================================
  // Warm-up pushes every stage so stale payload drains out
  assign iter.ex1_pipedown = iter.iter_start || warm_up;
  assign ex2_pipedown      = (st_is_iter && iter.last_round) || warm_up;
  assign ex3_pipedown      = st_is_rnd || warm_up;
  assign ex4_pipedown      = st_is_pack || warm_up;

  //==================================================
  // Datapath selects and status
  //==================================================
  assign op1_sel      = st_is_wfi2 || st_is_id1;
  assign save_ff1_op1 = st_is_wfi2;
  // Keep normalized op0 while op1 still needs its own pass
  assign save_op0     = st_is_id0 && dn_op1;

  assign wb_req     = st_is_wfwb;
  assign state_idle = st_is_idle;
  assign srt_sm_on  = st_is_iter;
  assign busy       = !st_is_idle && !st_is_wfi2 && !st_is_id0 && !st_is_id1;

  //==================================================
  // Assertions
  //==================================================
  // A pending result never coexists with an ex1 stall
  a_req_no_stall: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    !(wb_req && ex1_stall));

  // Any flush lands the sequencer in idle
  a_flush_idle: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    flush |=> state_idle);

endmodule

// File: design/fdsu_iter_if.sv
// Control link between the sequencing state machine and the SRT iteration counter
`timescale 1ns/1ns

interface fdsu_iter_if;

  // Counter load, one cycle before the first iterate cycle
  logic iter_start;
  // High throughout the iterate state
  logic itering;
  // Instruction leaves ex1
  logic ex1_pipedown;
  // Warm-up or asynchronous flush
  logic flush;
  // Final iterate cycle
  logic last_round;

  modport fsm (
    output iter_start, itering, ex1_pipedown, flush,
    input  last_round
  );

  modport cnt (
    input  iter_start, itering, ex1_pipedown, flush,
    output last_round
  );

endinterface

// File: design/fdsu_ctrl_pkg.sv
// State encoding used by the divide/sqrt sequencing state machine
package fdsu_ctrl_pkg;

  //==================================================
  // Sequencer state
  //==================================================
  localparam int unsigned FDSU_STATE_W = 3;

  // Codes follow the legacy datapath encoding
  typedef enum logic [FDSU_STATE_W-1:0] {
    // Waiting for an issue
    st_idle = 3'd0,
    // Wait one cycle before op1 normalization
    st_wfi2 = 3'd1,
    // SRT iteration
    st_iter = 3'd2,
    // Rounding
    st_rnd  = 3'd3,
    // Result packing
    st_pack = 3'd4,
    // Holding the writeback request until grant
    st_wfwb = 3'd5,
    // Denormal op0 normalization
    st_id0  = 3'd6,
    // Denormal op1 normalization
    st_id1  = 3'd7
  } fdsu_state_e;

endpackage

// File: design/fdsu_format_pkg.sv
// Floating-point format codes and SRT iteration start counts shared by the counter and testbench
package fdsu_format_pkg;

  //==================================================
  // Format encoding
  //==================================================
  // One code per operand format, issued alongside ex1_sel
  typedef enum logic [1:0] {
    fmt_double = 2'd0,
    fmt_single = 2'd1,
    fmt_half   = 2'd2,
    fmt_bhalf  = 2'd3
  } fdsu_fmt_e;

  //==================================================
  // Iteration counter
  //==================================================
  // Wide enough for the double-precision start value
  localparam int unsigned SRT_CNT_W = 5;

  // Start values, the iterate state runs one cycle more than each
  // Double needs 29 radix-4 rounds for its 53-bit quotient
  localparam logic [SRT_CNT_W-1:0] SRT_CNT_DOUBLE = 5'd28;

  // Single, 24-bit mantissa plus guard bits
  localparam logic [SRT_CNT_W-1:0] SRT_CNT_SINGLE = 5'd13;

  // Half precision
  localparam logic [SRT_CNT_W-1:0] SRT_CNT_HALF   = 5'd7;

  // Bfloat16 has the shortest mantissa
  localparam logic [SRT_CNT_W-1:0] SRT_CNT_BHALF  = 5'd5;

endpackage
